/* verilog/sram_pkg.sv */
package sram_pkg;

   // ==========================================================
   // logical word geometry.
   // ==========================================================
   localparam int DATA_W      = 132;              // full logical word.
   localparam int LANE_W      = 33;               // one logical lane.
   localparam int LANES       = 4;                // lanes per word.
   localparam int LANE_IDX_W  = 2;                // bits to number a lane.

   // ==========================================================
   // physical word geometry of the block RAM.
   // ==========================================================
   localparam int BYTE_W      = 8;                // write mask granule.
   localparam int LANE_BYTES  = 5;                // bytes per physical lane.
   localparam int PHYS_LANE_W = LANE_BYTES * BYTE_W;  // 40, top 7 bits are pad.
   localparam int PHYS_W      = LANES * PHYS_LANE_W;  // 160.
   localparam int MASK_W      = LANES * LANE_BYTES;   // 20 byte enables.

   // self-test command, sampled every cycle.
   typedef enum logic [1:0] {
      BIST_NOP   = 2'd0,                          // no request.
      BIST_RUN   = 2'd1,                          // start a run from idle.
      BIST_ABORT = 2'd2                           // drop a run in progress.
   } bist_cmd_e;

   // march sequence states.
   typedef enum logic [2:0] {
      ST_IDLE = 3'd0,                             // functional port owns the RAM.
      ST_WR0  = 3'd1,                             // pass 0, write P(a) ascending.
      ST_RD0  = 3'd2,                             // pass 1, read.
      ST_CMP0 = 3'd3,                             // pass 1, check against P(a).
      ST_WR1  = 3'd4,                             // pass 1, write ~P(a).
      ST_RD1  = 3'd5,                             // pass 2, read descending.
      ST_CMP1 = 3'd6,                             // pass 2, check against ~P(a).
      ST_DONE = 3'd7                              // one cycle, raises done.
   } bist_state_e;

endpackage

/* verilog/bram_128x160.sv */
module bram_128x160 #(
   parameter int ADDR_W = 7
) (
   // write port.
   input  logic                          clka,
   input  logic                          ena,
   input  logic [sram_pkg::MASK_W-1:0]   wea,
   input  logic [ADDR_W-1:0]             addra,
   input  logic [sram_pkg::PHYS_W-1:0]   dina,
   // read port.
   input  logic                          clkb,
   input  logic                          enb,
   input  logic [ADDR_W-1:0]             addrb,
   output logic [sram_pkg::PHYS_W-1:0]   doutb
);

   localparam int DEPTH = 1 << ADDR_W;            // entries in the array.

   // ==========================================================
   // storage array, no reset.
   // ==========================================================
   logic [sram_pkg::PHYS_W-1:0] mem [DEPTH];

   // byte granular write on port a.
   always_ff @(posedge clka) begin
      if (ena) begin
         for (int i = 0; i < sram_pkg::MASK_W; i++) begin
            if (wea[i]) begin
               mem[addra][i*sram_pkg::BYTE_W +: sram_pkg::BYTE_W] <=
                  dina[i*sram_pkg::BYTE_W +: sram_pkg::BYTE_W];   // one byte lane.
            end
         end
      end
   end

   // ==========================================================
   // registered read on port b.
   // ==========================================================
   // output register holds between reads.
   always_ff @(posedge clkb) begin
      if (enb) begin
         doutb <= mem[addrb];                     // data valid the next cycle.
      end
   end

endmodule

/* verilog/sram_1rw_128x132.sv */
module sram_1rw_128x132 #(
   parameter int ADDR_W = 7
) (
   input  logic                          memclk,
   input  logic                          ce,        // port select.
   input  logic                          rdwen,     // 1 reads, 0 writes.
   input  logic [ADDR_W-1:0]             addr,
   input  logic [sram_pkg::DATA_W-1:0]   bw,        // only bit 0 of each lane counts.
   input  logic [sram_pkg::DATA_W-1:0]   din,
   output logic [sram_pkg::DATA_W-1:0]   dout
);

   logic                          write_en;       // port a enable.
   logic                          read_en;        // port b enable.
   logic [sram_pkg::MASK_W-1:0]   wen_mask;       // per byte write enables.
   logic [sram_pkg::PHYS_W-1:0]   data_in;        // padded write word.
   logic [sram_pkg::PHYS_W-1:0]   data_out;       // padded read word.

   // ==========================================================
   // port decode.
   // ==========================================================
   assign write_en = ce & ~rdwen;
   assign read_en  = ce & rdwen;

   // ==========================================================
   // lane packing, 33 logical bits into 40 physical bits.
   // ==========================================================
   for (genvar i = 0; i < sram_pkg::LANES; i++) begin : g_lane
      // one mask bit fans out to all five bytes of the lane.
      assign wen_mask[i*sram_pkg::LANE_BYTES +: sram_pkg::LANE_BYTES] =
         {sram_pkg::LANE_BYTES{bw[i*sram_pkg::LANE_W]}};

      // pad bits at the top of the physical lane are zero.
      assign data_in[i*sram_pkg::PHYS_LANE_W +: sram_pkg::PHYS_LANE_W] =
         {{(sram_pkg::PHYS_LANE_W - sram_pkg::LANE_W){1'b0}},
          din[i*sram_pkg::LANE_W +: sram_pkg::LANE_W]};

      // read back only the low 33 bits, pad is dropped.
      assign dout[i*sram_pkg::LANE_W +: sram_pkg::LANE_W] =
         data_out[i*sram_pkg::PHYS_LANE_W +: sram_pkg::LANE_W];
   end

   // single port, both RAM ports share the address.
   bram_128x160 #(
      .ADDR_W (ADDR_W)
   ) mem (
      .clka  (memclk),
      .ena   (write_en),
      .wea   (wen_mask),
      .addra (addr),
      .dina  (data_in),
      .clkb  (memclk),
      .enb   (read_en),
      .addrb (addr),
      .doutb (data_out)
   );

endmodule

/* verilog/sram_bist.sv */
module sram_bist #(
   parameter int ADDR_W = 7
) (
   input  logic                          memclk,
   input  logic                          rst,
   input  sram_pkg::bist_cmd_e           bist_cmd,
   // functional side.
   input  logic                          ce,
   input  logic                          rdwen,
   input  logic [ADDR_W-1:0]             addr,
   input  logic [sram_pkg::DATA_W-1:0]   bw,
   input  logic [sram_pkg::DATA_W-1:0]   din,
   // memory side.
   input  logic [sram_pkg::DATA_W-1:0]   mem_dout,
   output logic                          mem_ce,
   output logic                          mem_rdwen,
   output logic [ADDR_W-1:0]             mem_addr,
   output logic [sram_pkg::DATA_W-1:0]   mem_bw,
   output logic [sram_pkg::DATA_W-1:0]   mem_din,
   // status.
   output logic                          bist_busy,
   output logic                          bist_done,
   output logic                          bist_fail
);

   localparam logic [ADDR_W-1:0] ADDR_MAX = '1;   // last word of the array.

   sram_pkg::bist_state_e         state;          // march state.
   logic [ADDR_W-1:0]             cnt;            // march address.
   logic [sram_pkg::DATA_W-1:0]   pat;            // P(cnt).
   logic [sram_pkg::DATA_W-1:0]   pat_n;          // complement of P(cnt).
   logic                          abort_req;      // abort while a run is active.

   // ==========================================================
   // test pattern.
   // ==========================================================
   // low bits hold the address and the lane index sits just above them.
   function automatic logic [sram_pkg::DATA_W-1:0] pattern(input logic [ADDR_W-1:0] a);
      logic [sram_pkg::DATA_W-1:0] p;
      p = '0;
      for (int i = 0; i < sram_pkg::LANES; i++) begin
         p[i*sram_pkg::LANE_W +: ADDR_W] = a;
         p[i*sram_pkg::LANE_W + ADDR_W +: sram_pkg::LANE_IDX_W] =
            sram_pkg::LANE_IDX_W'(i);
      end
      return p;
   endfunction

   assign pat   = pattern(cnt);
   assign pat_n = ~pat;                           // inverse of every lane bit.

   // status decode from the state register.
   assign bist_busy = !(state inside {sram_pkg::ST_IDLE, sram_pkg::ST_DONE});
   assign bist_done = (state == sram_pkg::ST_DONE);   // single cycle by construction.
   assign abort_req = bist_busy && (bist_cmd == sram_pkg::BIST_ABORT);

   // ==========================================================
   // march sequencer.
   // ==========================================================
   always_ff @(posedge memclk) begin
      if (rst) begin
         state     <= sram_pkg::ST_IDLE;
         cnt       <= '0;
         bist_fail <= 1'b0;
      end else if (abort_req) begin
         state <= sram_pkg::ST_IDLE;              // no done pulse on abort.
      end else begin
         case (state)
            sram_pkg::ST_IDLE: begin
               if (bist_cmd == sram_pkg::BIST_RUN) begin
                  state     <= sram_pkg::ST_WR0;
                  cnt       <= '0;
                  bist_fail <= 1'b0;              // each run starts with a clear flag.
               end
            end
            sram_pkg::ST_WR0: begin
               cnt <= cnt + 1'b1;                 // wraps to 0 for pass 1.
               if (cnt == ADDR_MAX) state <= sram_pkg::ST_RD0;
            end
            sram_pkg::ST_RD0: state <= sram_pkg::ST_CMP0;
            sram_pkg::ST_CMP0: begin
               if (mem_dout != pat) bist_fail <= 1'b1;
               state <= sram_pkg::ST_WR1;
            end
            sram_pkg::ST_WR1: begin
               if (cnt == ADDR_MAX) begin
                  state <= sram_pkg::ST_RD1;      // pass 2 starts from the top.
               end else begin
                  cnt   <= cnt + 1'b1;
                  state <= sram_pkg::ST_RD0;
               end
            end
            sram_pkg::ST_RD1: state <= sram_pkg::ST_CMP1;
            sram_pkg::ST_CMP1: begin
               if (mem_dout != pat_n) bist_fail <= 1'b1;
               if (cnt == '0) begin
                  state <= sram_pkg::ST_DONE;
               end else begin
                  cnt   <= cnt - 1'b1;            // descending.
                  state <= sram_pkg::ST_RD1;
               end
            end
            default: state <= sram_pkg::ST_IDLE;  // ST_DONE lasts one cycle.
         endcase
      end
   end

   // ==========================================================
   // memory port mux.
   // ==========================================================
   always_comb begin
      if (bist_busy) begin
         // compare states leave the port idle while the read data is checked.
         mem_ce    = state inside {sram_pkg::ST_WR0, sram_pkg::ST_RD0,
                                   sram_pkg::ST_WR1, sram_pkg::ST_RD1};
         mem_rdwen = state inside {sram_pkg::ST_RD0, sram_pkg::ST_RD1};
         mem_addr  = cnt;
         mem_bw    = '1;                          // every lane written.
         mem_din   = (state == sram_pkg::ST_WR1) ? pat_n : pat;
      end else begin
         mem_ce    = ce;                          // functional port straight through.
         mem_rdwen = rdwen;
         mem_addr  = addr;
         mem_bw    = bw;
         mem_din   = din;
      end
      if (rst) mem_ce = 1'b0;                     // RAM port stays quiet in reset.
   end

endmodule

/* verilog/sram_macro_top.sv */
module sram_macro_top #(
   parameter int ADDR_W = 7                       // 128 words.
) (
   input  logic                          memclk,
   input  logic                          rst,
   // functional port.
   input  logic                          ce,
   input  logic                          rdwen,
   input  logic [ADDR_W-1:0]             addr,
   input  logic [sram_pkg::DATA_W-1:0]   bw,
   input  logic [sram_pkg::DATA_W-1:0]   din,
   output logic [sram_pkg::DATA_W-1:0]   dout,
   // self-test controls.
   input  sram_pkg::bist_cmd_e           bist_cmd,
   output logic                          bist_busy,
   output logic                          bist_done,
   output logic                          bist_fail
);

   // ==========================================================
   // engine to wrapper port.
   // ==========================================================
   logic                          mem_ce;
   logic                          mem_rdwen;
   logic [ADDR_W-1:0]             mem_addr;
   logic [sram_pkg::DATA_W-1:0]   mem_bw;
   logic [sram_pkg::DATA_W-1:0]   mem_din;

   // self-test engine sits in front of the wrapper.
   sram_bist #(
      .ADDR_W (ADDR_W)
   ) bist (
      .memclk    (memclk),
      .rst       (rst),
      .bist_cmd  (bist_cmd),
      .ce        (ce),
      .rdwen     (rdwen),
      .addr      (addr),
      .bw        (bw),
      .din       (din),
      .mem_dout  (dout),                          // read data seen by both sides.
      .mem_ce    (mem_ce),
      .mem_rdwen (mem_rdwen),
      .mem_addr  (mem_addr),
      .mem_bw    (mem_bw),
      .mem_din   (mem_din),
      .bist_busy (bist_busy),
      .bist_done (bist_done),
      .bist_fail (bist_fail)
   );

   // lane packing wrapper around the block RAM.
   sram_1rw_128x132 #(
      .ADDR_W (ADDR_W)
   ) sram (
      .memclk (memclk),
      .ce     (mem_ce),
      .rdwen  (mem_rdwen),
      .addr   (mem_addr),
      .bw     (mem_bw),
      .din    (mem_din),
      .dout   (dout)
   );

endmodule

/* sim/tb_clock.sv */
module tb_clock #(
   parameter int PERIOD = 100                     // full clock period.
) (
   output logic clk
);

   // free running, starts low.
   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

endmodule

/* sim/sram_sva.sv */
module sram_sva (
   input logic memclk,
   input logic rst,
   input logic mem_ce,
   input logic bist_busy,
   input logic bist_done
);

   // ==========================================================
   // self-test port control properties.
   // ==========================================================
   done_width: assert property (@(posedge memclk) disable iff (rst)
      bist_done |=> !bist_done)
      else $error("bist_done stayed high for more than one cycle.");

   // done only closes a run.
   done_after_busy: assert property (@(posedge memclk) disable iff (rst)
      bist_done |-> $past(bist_busy))
      else $error("bist_done pulsed without a run in progress.");

   quiet_reset: assert property (@(posedge memclk)
      rst |-> !$rose(mem_ce))                     // port stays idle in reset.
      else $error("mem_ce rose while reset was active.");

   idle_after_reset: assert property (@(posedge memclk)
      $fell(rst) |-> !bist_busy)
      else $error("bist_busy was high in the first cycle after reset.");

endmodule

bind sram_bist sram_sva march_checks (
   .memclk    (memclk),
   .rst       (rst),
   .mem_ce    (mem_ce),
   .bist_busy (bist_busy),
   .bist_done (bist_done)
);

/* sim/sram_tb.sv */
module sram_tb;

   localparam int ADDR_W  = 7;
   localparam int DEPTH   = 1 << ADDR_W;
   localparam int TIMEOUT = 2000;                 // cycles allowed for a done pulse.
   localparam logic [ADDR_W-1:0] PAD_ADDR = 7'd42;

   logic                          memclk;
   logic                          rst;
   logic                          ce;
   logic                          rdwen;
   logic [ADDR_W-1:0]             addr;
   logic [sram_pkg::DATA_W-1:0]   bw;
   logic [sram_pkg::DATA_W-1:0]   din;
   logic [sram_pkg::DATA_W-1:0]   dout;
   sram_pkg::bist_cmd_e           bist_cmd;
   logic                          bist_busy;
   logic                          bist_done;
   logic                          bist_fail;

   integer seed        = 32'h349d;
   int     data_errors = 0;                       // read data mismatches.
   int     ctrl_errors = 0;                       // flags and timeouts.

   logic [sram_pkg::DATA_W-1:0]   shadow [DEPTH]; // reference memory.
   logic [sram_pkg::DATA_W-1:0]   exp_dout;       // predicted read data.
   logic                          exp_valid;      // a read lands this cycle.
   logic                          model_hold;     // engine owns the port.
   logic                          reload_req;     // load ~P(a) after a run.

   tb_clock #(.PERIOD(100)) clock (.clk(memclk));

   sram_macro_top #(.ADDR_W(ADDR_W)) UUT (.*);

   // each lane holds the address in bits 6..0 and the lane number in 8..7.
   function automatic logic [sram_pkg::DATA_W-1:0] march_word(input int a, input bit inv);
      logic [sram_pkg::LANE_W-1:0]   v;
      logic [sram_pkg::DATA_W-1:0]   w;
      for (int i = 0; i < sram_pkg::LANES; i++) begin
         v = {24'd0, 2'(i), 7'(a)};
         w[i*sram_pkg::LANE_W +: sram_pkg::LANE_W] = inv ? ~v : v;
      end
      return w;
   endfunction

   function automatic logic [sram_pkg::DATA_W-1:0] rand_word();
      logic [159:0] r;
      r = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
      return r[sram_pkg::DATA_W-1:0];
   endfunction

   // mask with only the enable bit of lane i set.
   function automatic logic [sram_pkg::DATA_W-1:0] lane_bit(input int i);
      logic [sram_pkg::DATA_W-1:0] m;
      m = '0;
      m[i*sram_pkg::LANE_W] = 1'b1;
      return m;
   endfunction

   // ==========================================================
   // shadow model updated from the inputs sampled at each edge.
   // ==========================================================
   always @(posedge memclk) begin
      if (rst) begin
         exp_valid <= 1'b0;
      end else begin
         exp_valid <= ce && rdwen && !model_hold;
         if (ce && rdwen) exp_dout <= shadow[addr];   // visible one cycle later.
         if (ce && !rdwen && !model_hold) begin
            for (int i = 0; i < sram_pkg::LANES; i++) begin
               if (bw[i*sram_pkg::LANE_W]) begin
                  shadow[addr][i*sram_pkg::LANE_W +: sram_pkg::LANE_W] =
                     din[i*sram_pkg::LANE_W +: sram_pkg::LANE_W];
               end
            end
         end
         if (reload_req) begin
            for (int a = 0; a < DEPTH; a++) shadow[a] = march_word(a, 1'b1);
         end
      end
   end

   // read data is stable at the falling edge.
   always @(negedge memclk) begin
      if (exp_valid) begin
         assert (dout === exp_dout) else begin
            $display("ERROR: dout expected %h actual %h", exp_dout, dout);
            data_errors++;
         end
      end
   end

   task automatic expect_flag(input string name, input logic actual, input logic expected);
      assert (actual === expected) else begin
         $display("ERROR: %s expected %h actual %h", name, expected, actual);
         ctrl_errors++;
      end
   endtask

   // one port cycle driven on the rising edge.
   task automatic drive_op(input logic c, input logic r, input logic [ADDR_W-1:0] a,
                           input logic [sram_pkg::DATA_W-1:0] m,
                           input logic [sram_pkg::DATA_W-1:0] d);
      @(posedge memclk);
      ce    <= c;
      rdwen <= r;
      addr  <= a;
      bw    <= m;
      din   <= d;
   endtask

   task automatic random_op(input logic [sram_pkg::DATA_W-1:0] m);
      drive_op(1'b1, 1'($random(seed)), ADDR_W'($random(seed)), m, rand_word());
   endtask

   task automatic start_run();
      drive_op(1'b0, 1'b1, '0, '0, '0);
      model_hold <= 1'b1;
      @(posedge memclk);
      bist_cmd <= sram_pkg::BIST_RUN;
      @(posedge memclk);
      bist_cmd <= sram_pkg::BIST_NOP;             // sampled at this edge.
      @(negedge memclk);
      expect_flag("bist_busy", bist_busy, 1'b1);
   endtask

   task automatic wait_done();
      int n;
      n = 0;
      @(negedge memclk);
      while (!bist_done && n < TIMEOUT) begin
         @(negedge memclk);
         n++;
      end
      if (!bist_done) begin
         $display("timeout, no bist_done pulse within %0d cycles", TIMEOUT);
         ctrl_errors++;
      end else begin
         expect_flag("bist_busy", bist_busy, 1'b0);
         expect_flag("bist_fail", bist_fail, 1'b0);
      end
   endtask

   // ==========================================================
   // main sequence.
   // ==========================================================
   initial begin
      logic [ADDR_W-1:0] ra;
      rst        = 1'b1;
      ce         = 1'b0;
      rdwen      = 1'b1;
      addr       = '0;
      bw         = '0;
      din        = '0;
      bist_cmd   = sram_pkg::BIST_NOP;
      model_hold = 1'b0;
      reload_req = 1'b0;
      repeat (16) begin
         @(posedge memclk);
         ce <= ~ce;                               // strobes in reset must not reach the RAM.
      end
      rst <= 1'b0;
      @(negedge memclk);
      expect_flag("bist_busy", bist_busy, 1'b0);
      expect_flag("bist_done", bist_done, 1'b0);
      expect_flag("bist_fail", bist_fail, 1'b0);

      // fill every word and read it all back.
      for (int a = 0; a < DEPTH; a++) drive_op(1'b1, 1'b0, ADDR_W'(a), '1, rand_word());
      for (int a = 0; a < DEPTH; a++) drive_op(1'b1, 1'b1, ADDR_W'(a), '0, '0);
      repeat (200) random_op('1);                 // full mask traffic.
      repeat (400) random_op(rand_word());        // lane masks plus noise bits.

      // all-ones lanes must not reach the pad or a neighbour lane.
      for (int i = 0; i < sram_pkg::LANES; i++) begin
         drive_op(1'b1, 1'b0, PAD_ADDR, '1, '0);
         drive_op(1'b1, 1'b0, PAD_ADDR, lane_bit(i), '1);
         drive_op(1'b1, 1'b1, PAD_ADDR, '0, '0);
         drive_op(1'b1, 1'b1, PAD_ADDR + 1'b1, '0, '0);
      end

      // ==========================================================
      // full march run while the functional strobes are ignored.
      // ==========================================================
      start_run();
      repeat (40) random_op(rand_word());
      drive_op(1'b0, 1'b1, '0, '0, '0);
      wait_done();
      @(negedge memclk);
      expect_flag("bist_done", bist_done, 1'b0);
      @(posedge memclk);
      model_hold <= 1'b0;
      reload_req <= 1'b1;
      @(posedge memclk);
      reload_req <= 1'b0;
      for (int a = 0; a < DEPTH; a++) drive_op(1'b1, 1'b1, ADDR_W'(a), '0, '0);

      // abort in the middle of pass 1.
      start_run();
      repeat (300) @(posedge memclk);
      bist_cmd <= sram_pkg::BIST_ABORT;
      @(posedge memclk);
      bist_cmd <= sram_pkg::BIST_NOP;
      @(negedge memclk);
      expect_flag("bist_busy", bist_busy, 1'b0);
      repeat (20) begin
         expect_flag("bist_done", bist_done, 1'b0);
         @(negedge memclk);
      end
      @(posedge memclk);
      model_hold <= 1'b0;
      repeat (16) begin
         ra = ADDR_W'($random(seed));
         drive_op(1'b1, 1'b0, ra, '1, rand_word());
         drive_op(1'b1, 1'b1, ra, '0, '0);
      end
      drive_op(1'b0, 1'b1, '0, '0, '0);
      repeat (3) @(negedge memclk);

      $display("%0d data errors, %0d control errors", data_errors, ctrl_errors);
      if (data_errors == 0 && ctrl_errors == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

/* src.f */
verilog/sram_pkg.sv
verilog/bram_128x160.sv
verilog/sram_1rw_128x132.sv
verilog/sram_bist.sv
verilog/sram_macro_top.sv
sim/tb_clock.sv
sim/sram_sva.sv
sim/sram_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -j 0
TOP       = sram_tb
FLIST     = src.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

# pass only when the exact pass line appears in the output.
run: build
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

lint:
	$(VERILATOR) --lint-only --assert --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
